// File: verilog/fetch_cfg.svh
// Fetch front end configuration
// Word width, byte count, boot address and memory model depth

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

////////////////////
// Datapath

`define FETCH_XLEN      32            // Instruction and address width
`define FETCH_NBYTES    4             // Bytes per instruction word

////////////////////
// Reset and memory

`define FETCH_BOOT_ADDR 32'h8000_0000 // First fetch after reset
`define FETCH_MEM_WORDS 256           // Testbench memory model depth in words

`endif

// File: verilog/fetch_pkg.sv
// Fetch front end types
// Word and address types, opcode classes and the two stream payloads

`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

  ////////////////////
  // Basic types

  typedef logic [`FETCH_XLEN-1:0] word_t;  // One instruction word
  typedef logic [`FETCH_XLEN-1:0] addr_t;  // One byte address

  ////////////////////
  // Opcode classes

  typedef enum logic [3:0] {
    LOAD      = 4'd0,
    STORE     = 4'd1,
    BRANCH    = 4'd2,
    JAL       = 4'd3,
    JALR      = 4'd4,
    OP_IMM    = 4'd5,
    OP        = 4'd6,
    UPPER     = 4'd7,   // LUI and AUIPC
    SYSTEM    = 4'd8,
    ILLEGAL   = 4'd9,   // Unknown opcode or bad low bits
    FETCH_ERR = 4'd10   // Bus error on the fetch
  } instr_class_e;

  ////////////////////
  // Stream payloads

  // Fetch unit to predecode, 33 bits
  typedef struct packed {
    word_t instr;
    logic  error;       // Bus error beside the word
  } fetch_word_t;

  // Predecode to decoder skid buffer, 37 bits
  typedef struct packed {
    word_t        instr;
    instr_class_e cls;
    logic         error;
  } predec_t;

endpackage

`default_nettype wire

// File: verilog/fetch_stream_if.sv
// Valid/ready stream link between pipeline stages
// Payload type set per instance, flush runs alongside the data

`timescale 1ns/1ps
`default_nettype none

interface fetch_stream_if #(
  parameter type PAYLOAD = logic
) ();

  logic   valid;   // Source has an item
  logic   ready;   // Sink takes it this cycle
  PAYLOAD data;
  logic   flush;   // Drop everything in flight, from the fetch unit

  // Producer side, the fetch unit also drives flush here
  modport source (
    output valid,
    output data,
    output flush,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  data,
    input  flush,
    output ready
  );

endinterface

`default_nettype wire

// File: verilog/fetch_unit.sv
// Instruction fetch unit
// Issues sequential word reads, catches responses in a two-register skid
// buffer and redirects on aligned jumps. Misaligned targets raise a pulse.

`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_unit (
  input  wire                      clk_i,
  input  wire                      rstn_i,
  // Memory request
  output fetch_pkg::addr_t         imem_req_addr_o,
  output logic                     imem_req_valid_o,
  input  wire                      imem_req_ready_i,
  // Memory response
  input  wire fetch_pkg::word_t    imem_rsp_data_i,
  input  wire                      imem_rsp_error_i,
  input  wire                      imem_rsp_valid_i,
  output logic                     imem_rsp_ready_o,
  // Jump and exception
  input  wire                      jmp_valid_i,
  input  wire fetch_pkg::addr_t    jmp_addr_i,
  output logic                     misalign_o,
  output fetch_pkg::addr_t         fault_addr_o,
  // Toward predecode
  fetch_stream_if.source           fetch_o
);

  localparam int unsigned OFS_W = $clog2(`FETCH_NBYTES);  // Byte offset bits

  typedef enum logic [1:0] {
    ST_EMPTY,  // Nothing held
    ST_BUSY,   // Output register holds a word
    ST_FULL,   // Output and skid register both hold a word
    ST_JUMP    // Waiting to issue the jump target
  } fsm_e;

  fsm_e state_q, state_d;

  fetch_pkg::fetch_word_t rsp_word;  // Incoming word with its error bit
  fetch_pkg::fetch_word_t skid_q;    // Response register
  fetch_pkg::fetch_word_t out_q;     // Output register

  logic req_fire, rsp_fire, out_fire;
  logic jmp_ok, jmp_bad;
  logic load, flow, fill, drain, unload, jmp_done;

  assign req_fire = imem_req_valid_o && imem_req_ready_i;
  assign rsp_fire = imem_rsp_valid_i && imem_rsp_ready_o;
  assign out_fire = fetch_o.valid && fetch_o.ready;

  // Jump gated by target alignment
  assign jmp_ok  = jmp_valid_i && (jmp_addr_i[OFS_W-1:0] == '0);
  assign jmp_bad = jmp_valid_i && (jmp_addr_i[OFS_W-1:0] != '0);

  assign rsp_word.instr = imem_rsp_data_i;
  assign rsp_word.error = imem_rsp_error_i;

  ////////////////////
  // Skid registers

  always_ff @(posedge clk_i) begin
    if (fill) begin
      skid_q <= rsp_word;  // Park the word while output is stalled
    end
    if (load || flow || drain) begin
      out_q <= drain ? skid_q : rsp_word;
    end
  end

  assign fetch_o.data  = out_q;
  assign fetch_o.flush = jmp_ok;  // Same cycle as the strobe

  ////////////////////
  // FSM

  always_comb begin
    load     = (state_q == ST_EMPTY) &&  rsp_fire;
    flow     = (state_q == ST_BUSY)  &&  rsp_fire &&  out_fire;
    fill     = (state_q == ST_BUSY)  &&  rsp_fire && ~out_fire;
    unload   = (state_q == ST_BUSY)  && ~rsp_fire &&  out_fire;
    drain    = (state_q == ST_FULL)  &&  out_fire;  // No response lands in FULL
    jmp_done = (state_q == ST_JUMP)  &&  req_fire;
  end

  always_comb begin
    state_d = state_q;
    if (load || flow || drain) state_d = ST_BUSY;
    if (fill)                  state_d = ST_FULL;
    if (unload)                state_d = ST_EMPTY;
    if (jmp_done)              state_d = ST_EMPTY;  // Target request is out
    if (jmp_ok)                state_d = ST_JUMP;   // A new jump wins
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q          <= ST_EMPTY;
      imem_req_valid_o <= 1'b0;
      imem_rsp_ready_o <= 1'b0;
      fetch_o.valid    <= 1'b0;
    end else begin
      state_q          <= state_d;
      // Request only if the held words plus the one in flight leave room
      imem_req_valid_o <= (state_d == ST_JUMP) || (state_d == ST_EMPTY) ||
                          ((state_d == ST_BUSY) && !req_fire);
      imem_rsp_ready_o <= (state_d != ST_FULL);
      fetch_o.valid    <= (state_d == ST_BUSY) || (state_d == ST_FULL);
    end
  end

  ////////////////////
  // Fetch address

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      imem_req_addr_o <= `FETCH_BOOT_ADDR;
    end else if (jmp_ok) begin
      imem_req_addr_o <= jmp_addr_i;  // Redirect
    end else if (req_fire) begin
      imem_req_addr_o <= imem_req_addr_o + fetch_pkg::addr_t'(`FETCH_NBYTES);
    end
  end

  // Misaligned target, pulse and keep fetching
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      misalign_o <= 1'b0;
    end else begin
      misalign_o <= jmp_bad;
    end
  end

  always_ff @(posedge clk_i) begin
    if (jmp_bad) begin
      fault_addr_o <= jmp_addr_i;  // Held until the next fault
    end
  end

endmodule

`default_nettype wire

// File: verilog/instr_predecode.sv
// Instruction predecode stage
// Classifies each fetched word by its opcode in one pipeline register

`timescale 1ns/1ps
`default_nettype none

module instr_predecode (
  input  wire            clk_i,
  input  wire            rstn_i,
  fetch_stream_if.sink   in_i,    // fetch_word_t payload
  fetch_stream_if.source out_o    // predec_t payload
);

  // RV32I major opcodes, bits 6:2
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;
  localparam logic [4:0] OPC_JAL    = 5'b11011;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_OP_IMM = 5'b00100;
  localparam logic [4:0] OPC_OP     = 5'b01100;
  localparam logic [4:0] OPC_LUI    = 5'b01101;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_SYSTEM = 5'b11100;

  fetch_pkg::fetch_word_t  in_word;
  fetch_pkg::instr_class_e cls;
  fetch_pkg::predec_t      pkt_q;   // Pipeline register
  logic                    valid_q;
  logic [4:0]              opcode;

  assign in_word = in_i.data;
  assign opcode  = in_word.instr[6:2];

  ////////////////////
  // Classification

  always_comb begin
    case (opcode)
      OPC_LOAD:           cls = fetch_pkg::LOAD;
      OPC_STORE:          cls = fetch_pkg::STORE;
      OPC_BRANCH:         cls = fetch_pkg::BRANCH;
      OPC_JAL:            cls = fetch_pkg::JAL;
      OPC_JALR:           cls = fetch_pkg::JALR;
      OPC_OP_IMM:         cls = fetch_pkg::OP_IMM;
      OPC_OP:             cls = fetch_pkg::OP;
      OPC_LUI, OPC_AUIPC: cls = fetch_pkg::UPPER;
      OPC_SYSTEM:         cls = fetch_pkg::SYSTEM;
      default:            cls = fetch_pkg::ILLEGAL;
    endcase
    // Compressed or garbage encodings
    if (in_word.instr[1:0] != 2'b11) cls = fetch_pkg::ILLEGAL;
    if (in_word.error)               cls = fetch_pkg::FETCH_ERR;  // Bus error wins
  end

  ////////////////////
  // Pipeline register

  // Take a new word when empty or when the held one leaves
  assign in_i.ready = !valid_q || out_o.ready;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      valid_q <= 1'b0;
    end else if (in_i.flush) begin
      valid_q <= 1'b0;           // Drop on jump
    end else if (in_i.ready) begin
      valid_q <= in_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_i.valid && in_i.ready) begin
      pkt_q.instr <= in_word.instr;
      pkt_q.cls   <= cls;
      pkt_q.error <= in_word.error;
    end
  end

  assign out_o.valid = valid_q;
  assign out_o.data  = pkt_q;

endmodule

`default_nettype wire

// File: verilog/dec_skid_buffer.sv
// Decoder side skid buffer
// Main and spare entry so the upstream ready can come from a register

`timescale 1ns/1ps
`default_nettype none

module dec_skid_buffer (
  input  wire                            clk_i,
  input  wire                            rstn_i,
  fetch_stream_if.sink                   in_i,         // predec_t payload
  output fetch_pkg::word_t               dec_instr_o,
  output fetch_pkg::instr_class_e        dec_class_o,
  output logic                           dec_error_o,
  output logic                           dec_valid_o,
  input  wire                            dec_ready_i
);

  fetch_pkg::predec_t main_q, spare_q;
  logic main_valid_q, spare_valid_q, ready_q;
  logic main_valid_d, spare_valid_d;
  logic load_main, load_spare, move_spare;
  logic in_fire, out_fire;

  assign in_fire  = in_i.valid && ready_q;
  assign out_fire = main_valid_q && dec_ready_i;

  ////////////////////
  // Entry control

  always_comb begin
    main_valid_d  = main_valid_q;
    spare_valid_d = spare_valid_q;
    load_main     = 1'b0;
    load_spare    = 1'b0;
    move_spare    = 1'b0;
    if (spare_valid_q) begin          // Upstream is stalled here
      if (out_fire) begin
        move_spare    = 1'b1;
        spare_valid_d = 1'b0;
      end
    end else if (!main_valid_q || out_fire) begin
      main_valid_d = in_fire;
      load_main    = in_fire;
    end else if (in_fire) begin
      spare_valid_d = 1'b1;           // Main stuck, catch the item
      load_spare    = 1'b1;
    end
    if (in_i.flush) begin
      main_valid_d  = 1'b0;
      spare_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
      ready_q       <= 1'b0;
    end else begin
      main_valid_q  <= main_valid_d;
      spare_valid_q <= spare_valid_d;
      ready_q       <= !spare_valid_d;  // Low only with both entries full
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main)  main_q  <= in_i.data;
    if (move_spare) main_q  <= spare_q;
    if (load_spare) spare_q <= in_i.data;
  end

  assign in_i.ready  = ready_q;
  assign dec_instr_o = main_q.instr;
  assign dec_class_o = main_q.cls;
  assign dec_error_o = main_q.error;
  assign dec_valid_o = main_valid_q;

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
// Instruction fetch front end
// Fetch unit, predecode and decoder skid buffer in a row

`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  wire                       clk_i,
  input  wire                       rstn_i,
  // Instruction memory request
  output fetch_pkg::addr_t          imem_req_addr_o,
  output logic                      imem_req_valid_o,
  input  wire                       imem_req_ready_i,
  // Instruction memory response
  input  wire fetch_pkg::word_t     imem_rsp_data_i,
  input  wire                       imem_rsp_error_i,
  input  wire                       imem_rsp_valid_i,
  output logic                      imem_rsp_ready_o,
  // Decoder
  output fetch_pkg::word_t          dec_instr_o,
  output fetch_pkg::instr_class_e   dec_class_o,
  output logic                      dec_error_o,
  output logic                      dec_valid_o,
  input  wire                       dec_ready_i,
  // Jump and exception
  input  wire                       jmp_valid_i,
  input  wire fetch_pkg::addr_t     jmp_addr_i,
  output logic                      misalign_o,
  output fetch_pkg::addr_t          fault_addr_o
);

  ////////////////////
  // Stage links

  fetch_stream_if #(.PAYLOAD(fetch_pkg::fetch_word_t)) s_fetch ();
  fetch_stream_if #(.PAYLOAD(fetch_pkg::predec_t))     s_predec ();

  assign s_predec.flush = s_fetch.flush;  // One flush for both stages

  fetch_unit i_fetch_unit (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .imem_req_addr_o  (imem_req_addr_o),
    .imem_req_valid_o (imem_req_valid_o),
    .imem_req_ready_i (imem_req_ready_i),
    .imem_rsp_data_i  (imem_rsp_data_i),
    .imem_rsp_error_i (imem_rsp_error_i),
    .imem_rsp_valid_i (imem_rsp_valid_i),
    .imem_rsp_ready_o (imem_rsp_ready_o),
    .jmp_valid_i      (jmp_valid_i),
    .jmp_addr_i       (jmp_addr_i),
    .misalign_o       (misalign_o),
    .fault_addr_o     (fault_addr_o),
    .fetch_o          (s_fetch.source)
  );

  instr_predecode i_instr_predecode (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .in_i   (s_fetch.sink),
    .out_o  (s_predec.source)
  );

  dec_skid_buffer i_dec_skid_buffer (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_i        (s_predec.sink),
    .dec_instr_o (dec_instr_o),
    .dec_class_o (dec_class_o),
    .dec_error_o (dec_error_o),
    .dec_valid_o (dec_valid_o),
    .dec_ready_i (dec_ready_i)
  );

endmodule

`default_nettype wire

// File: tb/fetch_checker.sv
// Fetch front end port assertions
// Decoder hold, misalign pulse width and request quiet in reset

`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_checker (
  input wire                          clk_i,
  input wire                          rstn_i,
  input wire                          imem_req_valid_o,
  input wire                          dec_valid_o,
  input wire                          dec_ready_i,
  input wire fetch_pkg::word_t        dec_instr_o,
  input wire fetch_pkg::instr_class_e dec_class_o,
  input wire                          dec_error_o,
  input wire                          jmp_valid_i,
  input wire fetch_pkg::addr_t        jmp_addr_i,
  input wire                          misalign_o
);

  localparam int unsigned OFS_W = $clog2(`FETCH_NBYTES);

  logic flush;  // Aligned jump empties the decoder buffer
  assign flush = jmp_valid_i && (jmp_addr_i[OFS_W-1:0] == '0);

  ////////////////////
  // Properties

  a_dec_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
    dec_valid_o && !dec_ready_i && !flush |=>
      dec_valid_o && $stable(dec_instr_o) && $stable(dec_class_o) && $stable(dec_error_o))
    else $error("decoder output dropped or changed before the transfer");

  a_misalign_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
    misalign_o |=> !misalign_o)
    else $error("misalign pulse longer than one cycle");

  // Synchronous reset, so checked one edge later
  a_req_reset: assert property (@(posedge clk_i) !rstn_i |=> !imem_req_valid_o)
    else $error("memory request raised during reset");

endmodule

bind fetch_top fetch_checker i_fetch_checker (
  .clk_i            (clk_i),
  .rstn_i           (rstn_i),
  .imem_req_valid_o (imem_req_valid_o),
  .dec_valid_o      (dec_valid_o),
  .dec_ready_i      (dec_ready_i),
  .dec_instr_o      (dec_instr_o),
  .dec_class_o      (dec_class_o),
  .dec_error_o      (dec_error_o),
  .jmp_valid_i      (jmp_valid_i),
  .jmp_addr_i       (jmp_addr_i),
  .misalign_o       (misalign_o)
);

`default_nettype wire

// File: tb/fetch_tb.sv
// Fetch front end testbench
// Random memory and decoder stalls, random jumps, and a reference
// check of every word that reaches the decoder

`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned DRIVE_DLY  = 2;      // Input skew after the edge
  localparam int unsigned RST_CYCLES = 16;
  localparam int unsigned N_ITEMS    = 500;    // Decoder transfers to check
  localparam int unsigned JUMP_START = 40;     // Jumps only after this many words
  localparam int unsigned IDLE_LIMIT = 200;    // Cycles without a decoder transfer
  localparam int unsigned RUN_LIMIT  = 20000;
  localparam int unsigned ERR_LO     = 20;     // Bus error window, words from boot
  localparam int unsigned ERR_HI     = 24;

  logic                    clk_i;
  logic                    rstn_i;
  fetch_pkg::addr_t        imem_req_addr_o;
  logic                    imem_req_valid_o;
  logic                    imem_req_ready_i;
  fetch_pkg::word_t        imem_rsp_data_i;
  logic                    imem_rsp_error_i;
  logic                    imem_rsp_valid_i;
  logic                    imem_rsp_ready_o;
  fetch_pkg::word_t        dec_instr_o;
  fetch_pkg::instr_class_e dec_class_o;
  logic                    dec_error_o;
  logic                    dec_valid_o;
  logic                    dec_ready_i;
  logic                    jmp_valid_i;
  fetch_pkg::addr_t        jmp_addr_i;
  logic                    misalign_o;
  fetch_pkg::addr_t        fault_addr_o;

  logic [31:0]             rng;                // xorshift state
  fetch_pkg::addr_t        tgt;
  fetch_pkg::addr_t        req_q[$];           // Accepted, not yet answered
  logic                    rsp_taken;
  fetch_pkg::addr_t        rsp_addr;
  fetch_pkg::addr_t        exp_addr = `FETCH_BOOT_ADDR;
  fetch_pkg::word_t        exp_word;
  logic                    exp_err;
  fetch_pkg::instr_class_e exp_cls;
  logic                    mis_pending = 1'b0;
  fetch_pkg::addr_t        fault_exp;
  int unsigned             xfer_count = 0;
  int unsigned             err_count  = 0;
  int unsigned             ill_count  = 0;
  int unsigned             jump_count = 0;
  int unsigned             mis_count  = 0;
  int unsigned             idle;
  int unsigned             cycles;
  int unsigned             last_count;

  fetch_top i_fetch_top (.*);

  ////////////////////
  // Models

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Memory image, every bit of the address feeds the hash
  function automatic fetch_pkg::word_t mem_word(input fetch_pkg::addr_t addr);
    logic [31:0] h;
    logic [6:0]  opc;
    fetch_pkg::word_t w;
    h = addr ^ {addr[15:0], addr[31:16]} ^ (addr >> 5);
    h = h * 32'h9e37_79b1;
    case (h[31:28])
      4'd0, 4'd13: opc = 7'h03;  // Load
      4'd1, 4'd14: opc = 7'h23;  // Store
      4'd2, 4'd15: opc = 7'h63;  // Branch
      4'd3:        opc = 7'h6f;  // JAL
      4'd4:        opc = 7'h67;  // JALR
      4'd5, 4'd11: opc = 7'h13;  // OP-IMM
      4'd6, 4'd12: opc = 7'h33;  // OP
      4'd7:        opc = 7'h37;  // LUI
      4'd8:        opc = 7'h17;  // AUIPC
      4'd9:        opc = 7'h73;  // System
      default:     opc = 7'h0b;  // Custom-0, not RV32I
    endcase
    w = {h[24:0], opc};
    if (addr[6:2] == 5'd13) w[1:0] = 2'b10;  // Compressed-looking word
    return w;
  endfunction

  function automatic logic in_err_window(input fetch_pkg::addr_t addr);
    fetch_pkg::addr_t idx;
    idx = (addr - `FETCH_BOOT_ADDR) >> 2;
    return (idx >= ERR_LO) && (idx < ERR_HI);
  endfunction

  // Class by the predecode rules, full 7-bit opcodes
  function automatic fetch_pkg::instr_class_e expect_class(input fetch_pkg::word_t word,
                                                           input logic error);
    if (error) return fetch_pkg::FETCH_ERR;
    if (word[1:0] != 2'b11) return fetch_pkg::ILLEGAL;
    case (word[6:0])
      7'h03:        return fetch_pkg::LOAD;
      7'h23:        return fetch_pkg::STORE;
      7'h63:        return fetch_pkg::BRANCH;
      7'h6f:        return fetch_pkg::JAL;
      7'h67:        return fetch_pkg::JALR;
      7'h13:        return fetch_pkg::OP_IMM;
      7'h33:        return fetch_pkg::OP;
      7'h37, 7'h17: return fetch_pkg::UPPER;
      7'h73:        return fetch_pkg::SYSTEM;
      default:      return fetch_pkg::ILLEGAL;
    endcase
  endfunction

  ////////////////////
  // Checks

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input fetch_pkg::word_t got,
                            input fetch_pkg::word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_class(input string name, input fetch_pkg::instr_class_e got,
                             input fetch_pkg::instr_class_e exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                            input fetch_pkg::addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Reset, stalls and jumps

  initial begin
    rng              = 32'he47d;
    rstn_i           = 1'b0;
    imem_req_ready_i = 1'b0;
    dec_ready_i      = 1'b0;
    jmp_valid_i      = 1'b0;
    jmp_addr_i       = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rstn_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #DRIVE_DLY;
      rng              = xorshift32(rng);
      imem_req_ready_i = (rng[2:0] != 3'd0);     // Stall 1 in 8
      dec_ready_i      = (rng[4:3] != 2'd0);     // Stall 1 in 4
      // No back-to-back strobes
      if (!jmp_valid_i && xfer_count >= JUMP_START && rng[11:8] == 4'd0) begin
        tgt = `FETCH_BOOT_ADDR +
              (fetch_pkg::addr_t'(rng[31:16]) % `FETCH_MEM_WORDS) * `FETCH_NBYTES;
        if (rng[25:24] == 2'd0) begin            // Misaligned 1 in 4
          tgt[1:0] = (rng[27:26] == 2'd0) ? 2'd2 : rng[27:26];
        end
        jmp_addr_i  = tgt;
        jmp_valid_i = 1'b1;
      end else begin
        jmp_valid_i = 1'b0;
      end
    end
  end

  ////////////////////
  // Instruction memory

  // Sample mid-cycle, answer right after the next edge
  initial begin
    imem_rsp_valid_i = 1'b0;
    imem_rsp_data_i  = '0;
    imem_rsp_error_i = 1'b0;
    forever begin
      @(negedge clk_i);
      rsp_taken = rstn_i && imem_rsp_valid_i && imem_rsp_ready_o;
      if (rstn_i && imem_req_valid_o && imem_req_ready_i) req_q.push_back(imem_req_addr_o);
      @(posedge clk_i);
      #DRIVE_DLY;
      if (rsp_taken) imem_rsp_valid_i = 1'b0;
      if (!imem_rsp_valid_i && req_q.size() != 0) begin
        rsp_addr         = req_q.pop_front();
        imem_rsp_data_i  = mem_word(rsp_addr);
        imem_rsp_error_i = in_err_window(rsp_addr);
        imem_rsp_valid_i = 1'b1;
      end
    end
  end

  ////////////////////
  // Compare

  always @(negedge clk_i) begin
    if (rstn_i) begin
      check_flag("misalign_o", misalign_o, mis_pending);
      if (mis_pending) begin
        check_addr("fault_addr_o", fault_addr_o, fault_exp);
        mis_count++;
      end
      if (dec_valid_o && dec_ready_i) begin    // Pre-jump item even with a strobe
        exp_word = mem_word(exp_addr);
        exp_err  = in_err_window(exp_addr);
        exp_cls  = expect_class(exp_word, exp_err);
        check_word("dec_instr_o", dec_instr_o, exp_word);
        check_flag("dec_error_o", dec_error_o, exp_err);
        check_class("dec_class_o", dec_class_o, exp_cls);
        if (exp_err) err_count++;
        if (exp_cls == fetch_pkg::ILLEGAL) ill_count++;
        exp_addr = exp_addr + `FETCH_NBYTES;
        xfer_count++;
      end
      mis_pending = jmp_valid_i && (jmp_addr_i[1:0] != 2'b00);
      if (mis_pending) fault_exp = jmp_addr_i;
      if (jmp_valid_i && jmp_addr_i[1:0] == 2'b00) begin
        exp_addr = jmp_addr_i;                   // Redirect
        jump_count++;
      end
    end
  end

  ////////////////////
  // Run control

  initial begin
    cycles = 0;
    while (!rstn_i) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > 2 * RST_CYCLES) begin
        $display("Timeout: reset was never released");
        abort_run();
      end
    end
    idle       = 0;
    cycles     = 0;
    last_count = 0;
    while (xfer_count < N_ITEMS) begin
      @(posedge clk_i);
      cycles++;
      if (xfer_count != last_count) begin
        last_count = xfer_count;
        idle       = 0;
      end else begin
        idle++;
      end
      if (idle > IDLE_LIMIT) begin
        $display("Timeout: no word reached the decoder for %0d cycles", IDLE_LIMIT);
        abort_run();
      end else if (cycles > RUN_LIMIT) begin
        $display("Timeout: only %0d of %0d words decoded", xfer_count, N_ITEMS);
        abort_run();
      end
    end
    if (err_count != 0 && ill_count != 0 && jump_count != 0 && mis_count != 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("Missing cases: errors %0d illegal %0d jumps %0d misaligned %0d",
               err_count, ill_count, jump_count, mis_count);
      abort_run();
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_stream_if.sv
verilog/fetch_unit.sv
verilog/instr_predecode.sv
verilog/dec_skid_buffer.sv
verilog/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fetch_tb
FILELIST = filelist.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(filter-out +%,$(shell cat $(FILELIST)))
HDRS     = $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only if the simulation prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
